// File: common/color_matrix_defs.svh
`ifndef COLOR_MATRIX_DEFS_SVH
`define COLOR_MATRIX_DEFS_SVH

// pixel channel and coefficient format
`define CM_DATA_WIDTH       10
`define CM_COEFF_FRAC       8
`define CM_COEFF_WIDTH      17
`define CM_INTERNAL_WIDTH   12

// parameter port map
// 0..11 coefficients row-major, 12..14 clip pairs, 15 unused
`define CM_PARAM_ADDR_WIDTH 4
`define CM_ADDR_CLIP0       12

`endif

// File: common/color_matrix_pkg.sv
`include "color_matrix_defs.svh"

package color_matrix_pkg;

    // ----------------------------------------
    // video stream
    // ----------------------------------------

    typedef struct packed {
        logic row_first;
        logic row_last;
        logic col_first;
        logic col_last;
        logic de;
    } img_side_t;

    typedef struct packed {
        img_side_t                          side;
        logic [2:0][`CM_DATA_WIDTH-1:0]     color;
    } img_beat_t;

    // ----------------------------------------
    // matrix parameters
    // ----------------------------------------

    // signed fixed point, 8 fraction bits
    typedef logic signed [`CM_COEFF_WIDTH-1:0] coeff_t;

    // index = row * 4 + column, column 3 is the offset
    typedef coeff_t [11:0] coeff_set_t;

    typedef struct packed {
        logic [`CM_DATA_WIDTH-1:0] max;
        logic [`CM_DATA_WIDTH-1:0] min;
    } clip_pair_t;

    typedef clip_pair_t [2:0] clip_set_t;

    typedef struct packed {
        logic [2:0] pad;
        coeff_t     value;
    } param_coeff_t;

    // view selected by the parameter address
    typedef union packed {
        param_coeff_t coeff;
        clip_pair_t   clip;
    } param_word_u;

endpackage

// File: color_matrix/color_matrix_ctrl.sv
`include "color_matrix_defs.svh"

module color_matrix_ctrl (
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                s_valid,
    input  color_matrix_pkg::img_side_t         s_side,
    input  logic                                m_valid,
    input  logic                                m_ready,

    input  logic                                param_req,
    input  logic [`CM_PARAM_ADDR_WIDTH-1:0]     param_addr,
    input  color_matrix_pkg::param_word_u       param_data,
    output logic                                param_ack,

    output logic                                cke,
    output color_matrix_pkg::coeff_set_t        coeff,
    output color_matrix_pkg::clip_set_t         clip
);

    function automatic color_matrix_pkg::coeff_set_t identity_coeff();
        color_matrix_pkg::coeff_set_t c;
        // diagonal sits at indices 0, 5 and 10
        for (int i = 0; i < 12; i++) begin
            c[i] = (i % 5 == 0) ? `CM_COEFF_WIDTH'(1 << `CM_COEFF_FRAC) : '0;
        end
        return c;
    endfunction

    function automatic color_matrix_pkg::clip_set_t identity_clip();
        color_matrix_pkg::clip_set_t c;
        for (int i = 0; i < 3; i++) begin
            c[i].min = '0;
            c[i].max = '1;
        end
        return c;
    endfunction

    logic                                       param_wr;
    logic [1:0]                                 clip_idx;
    logic                                       frame_start;

    color_matrix_pkg::coeff_set_t               shadow_coeff;
    color_matrix_pkg::coeff_set_t               active_coeff;
    color_matrix_pkg::clip_set_t                shadow_clip;
    color_matrix_pkg::clip_set_t                active_clip;
    color_matrix_pkg::clip_set_t                clip_p1;
    color_matrix_pkg::clip_set_t                clip_p2;

    // ----------------------------------------
    // parameter port
    // ----------------------------------------

    assign param_wr = param_req && !param_ack;
    assign clip_idx = 2'(param_addr - `CM_PARAM_ADDR_WIDTH'(`CM_ADDR_CLIP0));

    // ack follows req one cycle late
    always_ff @(posedge clk) begin
        if (reset) begin
            param_ack <= 1'b0;
        end else begin
            param_ack <= param_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            shadow_coeff <= identity_coeff();
            shadow_clip  <= identity_clip();
        end else if (param_wr) begin
            if (param_addr < `CM_ADDR_CLIP0) begin
                shadow_coeff[param_addr] <= param_data.coeff.value;
            end else if (param_addr < `CM_ADDR_CLIP0 + 3) begin
                shadow_clip[clip_idx] <= param_data.clip;
            end
        end
    end

    // ----------------------------------------
    // bank swap and pipeline enable
    // ----------------------------------------

    assign cke         = !m_valid || m_ready;
    assign frame_start = cke && s_valid && s_side.row_first && s_side.col_first;

    always_ff @(posedge clk) begin
        if (reset) begin
            active_coeff <= identity_coeff();
            active_clip  <= identity_clip();
        end else if (frame_start) begin
            active_coeff <= shadow_coeff;
            active_clip  <= shadow_clip;
        end
    end

    // frame-start beat already uses the incoming set
    assign coeff = frame_start ? shadow_coeff : active_coeff;

    // clip limits follow their beat through both mac stages
    always_ff @(posedge clk) begin
        if (reset) begin
            clip_p1 <= identity_clip();
            clip_p2 <= identity_clip();
        end else if (cke) begin
            clip_p1 <= frame_start ? shadow_clip : active_clip;
            clip_p2 <= clip_p1;
        end
    end

    assign clip = clip_p2;

    // ----------------------------------------
    // checks
    // ----------------------------------------

    // req stays up until the master has seen ack
    req_held: assert property (@(posedge clk) disable iff (reset)
        param_req && !param_ack |=> param_req);

    // master holds the word at least until it sees ack
    param_stable: assert property (@(posedge clk) disable iff (reset)
        param_req && !param_ack |=> $stable(param_addr) && $stable(param_data));

endmodule

// File: color_matrix/color_matrix_mac.sv
`include "color_matrix_defs.svh"

module color_matrix_mac (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cke,

    input  color_matrix_pkg::img_beat_t         s_beat,
    input  logic                                s_valid,
    input  color_matrix_pkg::coeff_set_t        coeff,

    output color_matrix_pkg::img_side_t         m_side,
    output logic signed [`CM_INTERNAL_WIDTH-1:0] m_color [3],
    output logic                                m_valid
);

    localparam int PROD_W = `CM_COEFF_WIDTH + `CM_DATA_WIDTH + 1;
    localparam int SUM_W  = PROD_W + 2;

    logic signed [`CM_DATA_WIDTH:0]             pix     [3];
    logic signed [PROD_W-1:0]                   prod    [3][3];
    logic signed [`CM_COEFF_WIDTH-1:0]          ofs     [3];
    color_matrix_pkg::img_side_t                side1;
    logic                                       valid1;
    logic signed [SUM_W-1:0]                    row_sum [3];

    // channels are unsigned, one zero bit on top
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            pix[c] = $signed({1'b0, s_beat.color[c]});
        end
    end

    // ----------------------------------------
    // stage 1: products and offsets
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (cke) begin
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    prod[r][c] <= $signed(coeff[r * 4 + c]) * pix[c];
                end
                ofs[r] <= coeff[r * 4 + 3];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid1 <= 1'b0;
            side1  <= '0;
        end else if (cke) begin
            valid1 <= s_valid;
            side1  <= s_valid ? s_beat.side : '0;
        end
    end

    // ----------------------------------------
    // stage 2: row sums, floor shift
    // ----------------------------------------

    always_comb begin
        for (int r = 0; r < 3; r++) begin
            row_sum[r] = prod[r][0] + prod[r][1] + prod[r][2] + ofs[r];
        end
    end

    // arithmetic shift then low bits is a plain slice
    always_ff @(posedge clk) begin
        if (cke) begin
            for (int r = 0; r < 3; r++) begin
                m_color[r] <= row_sum[r][`CM_COEFF_FRAC +: `CM_INTERNAL_WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
            m_side  <= '0;
        end else if (cke) begin
            m_valid <= valid1;
            m_side  <= side1;
        end
    end

    valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(m_valid));

endmodule

// File: color_matrix/color_matrix_clip.sv
`include "color_matrix_defs.svh"

module color_matrix_clip (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cke,

    input  color_matrix_pkg::img_side_t         s_side,
    input  logic signed [`CM_INTERNAL_WIDTH-1:0] s_color [3],
    input  logic                                s_valid,
    input  color_matrix_pkg::clip_set_t         clip,

    output color_matrix_pkg::img_beat_t         m_beat,
    output logic                                m_valid
);

    logic signed [`CM_INTERNAL_WIDTH-1:0]       lim_min [3];
    logic signed [`CM_INTERNAL_WIDTH-1:0]       lim_max [3];
    logic [2:0][`CM_DATA_WIDTH-1:0]             color_q;
    color_matrix_pkg::img_side_t                side_q;

    // limits are unsigned, zero extend before the signed compare
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            lim_min[c] = `CM_INTERNAL_WIDTH'(clip[c].min);
            lim_max[c] = `CM_INTERNAL_WIDTH'(clip[c].max);
        end
    end

    // max checked first so it wins
    always_ff @(posedge clk) begin
        if (cke) begin
            for (int c = 0; c < 3; c++) begin
                if (s_color[c] > lim_max[c]) begin
                    color_q[c] <= clip[c].max;
                end else if (s_color[c] < lim_min[c]) begin
                    color_q[c] <= clip[c].min;
                end else begin
                    color_q[c] <= s_color[c][`CM_DATA_WIDTH-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid <= 1'b0;
            side_q  <= '0;
        end else if (cke) begin
            m_valid <= s_valid;
            side_q  <= s_valid ? s_side : '0;
        end
    end

    assign m_beat = '{side: side_q, color: color_q};

    // limits used at the registering edge bound the output
    for (genvar c = 0; c < 3; c++) begin : g_range_chk
        in_range: assert property (@(posedge clk) disable iff (reset)
            cke && s_valid && clip[c].min <= clip[c].max |=>
                m_beat.color[c] >= $past(clip[c].min) &&
                m_beat.color[c] <= $past(clip[c].max));
    end

endmodule

// File: design/color_matrix_top.sv
`include "color_matrix_defs.svh"

module color_matrix_top (
    input  logic                                clk,
    input  logic                                reset,

    input  color_matrix_pkg::img_beat_t         s_beat,
    input  logic                                s_valid,
    output logic                                s_ready,

    output color_matrix_pkg::img_beat_t         m_beat,
    output logic                                m_valid,
    input  logic                                m_ready,

    input  logic                                param_req,
    input  logic [`CM_PARAM_ADDR_WIDTH-1:0]     param_addr,
    input  color_matrix_pkg::param_word_u       param_data,
    output logic                                param_ack
);

    logic                                       cke;
    color_matrix_pkg::coeff_set_t               coeff;
    color_matrix_pkg::clip_set_t                clip;

    color_matrix_pkg::img_side_t                mac_side;
    logic signed [`CM_INTERNAL_WIDTH-1:0]       mac_color [3];
    logic                                       mac_valid;

    // input accepted whenever the pipeline advances
    assign s_ready = cke;

    color_matrix_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .s_valid    (s_valid),
        .s_side     (s_beat.side),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .param_req  (param_req),
        .param_addr (param_addr),
        .param_data (param_data),
        .param_ack  (param_ack),
        .cke        (cke),
        .coeff      (coeff),
        .clip       (clip)
    );

    color_matrix_mac u_mac (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .coeff      (coeff),
        .m_side     (mac_side),
        .m_color    (mac_color),
        .m_valid    (mac_valid)
    );

    color_matrix_clip u_clip (
        .clk        (clk),
        .reset      (reset),
        .cke        (cke),
        .s_side     (mac_side),
        .s_color    (mac_color),
        .s_valid    (mac_valid),
        .clip       (clip),
        .m_beat     (m_beat),
        .m_valid    (m_valid)
    );

endmodule

// File: verif/tb_color_matrix.sv
`include "color_matrix_defs.svh"

module tb_color_matrix;

    localparam int TIMEOUT = 2000;

    logic                                   clk;
    logic                                   reset;
    color_matrix_pkg::img_beat_t            s_beat;
    logic                                   s_valid;
    logic                                   s_ready;
    color_matrix_pkg::img_beat_t            m_beat;
    logic                                   m_valid;
    logic                                   m_ready;
    logic                                   param_req;
    logic [`CM_PARAM_ADDR_WIDTH-1:0]        param_addr;
    color_matrix_pkg::param_word_u          param_data;
    logic                                   param_ack;

    integer                                 seed;
    logic                                   stall_en;
    int                                     error_count;
    int                                     fail_count;
    int                                     beat_count;

    // model of the two parameter banks
    int                                     sh_coef  [12];
    int                                     act_coef [12];
    int                                     sh_min   [3];
    int                                     sh_max   [3];
    int                                     act_min  [3];
    int                                     act_max  [3];
    color_matrix_pkg::img_beat_t            exp_q    [$];

    color_matrix_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .s_beat     (s_beat),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .m_beat     (m_beat),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .param_req  (param_req),
        .param_addr (param_addr),
        .param_data (param_data),
        .param_ack  (param_ack)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic color_matrix_pkg::img_beat_t expected_beat(
        input color_matrix_pkg::img_beat_t pixel,
        input int coef [12],
        input int lo [3],
        input int hi [3]
    );
        color_matrix_pkg::img_beat_t out;
        longint acc;
        longint shifted;
        int v;
        out.side = pixel.side;
        for (int r = 0; r < 3; r++) begin
            acc = coef[r * 4 + 3];
            for (int c = 0; c < 3; c++) begin
                acc += longint'(coef[r * 4 + c]) * longint'(pixel.color[c]);
            end
            // floor division by 256, then wrap to 12 bits signed
            shifted = acc >>> 8;
            v = int'(shifted & 64'hfff);
            if (v >= 2048) begin
                v -= 4096;
            end
            if (v > hi[r]) begin
                out.color[r] = 10'(hi[r]);
            end else if (v < lo[r]) begin
                out.color[r] = 10'(lo[r]);
            end else begin
                out.color[r] = 10'(v);
            end
        end
        return out;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, got, want);
            error_count++;
        end
    endtask

    // swap first, then the beat is computed with the active set
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 12; i++) begin
                sh_coef[i]  = (i == 0 || i == 5 || i == 10) ? 256 : 0;
                act_coef[i] = sh_coef[i];
            end
            for (int i = 0; i < 3; i++) begin
                sh_min[i]  = 0;
                sh_max[i]  = 1023;
                act_min[i] = 0;
                act_max[i] = 1023;
            end
            exp_q.delete();
        end else if (s_valid && s_ready) begin
            if (s_beat.side.row_first && s_beat.side.col_first) begin
                act_coef = sh_coef;
                act_min  = sh_min;
                act_max  = sh_max;
            end
            exp_q.push_back(expected_beat(s_beat, act_coef, act_min, act_max));
        end
    end

    // ----------------------------------------
    // output checker
    // ----------------------------------------

    always @(posedge clk) begin
        color_matrix_pkg::img_beat_t want;
        if (!reset) begin
            check_value("s_ready", s_ready, !(m_valid && !m_ready));
            if (!m_valid) begin
                check_value("m_beat.side", m_beat.side, '0);
            end
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat at t=%0t has no matching input beat", $time);
                    fail_count++;
                end else begin
                    want = exp_q.pop_front();
                    beat_count++;
                    for (int c = 0; c < 3; c++) begin
                        check_value($sformatf("m_beat.color[%0d]", c),
                                    m_beat.color[c], want.color[c]);
                    end
                    check_value("m_beat.side", m_beat.side, want.side);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (stall_en) begin
            m_ready <= ($random(seed) & 3) != 0;
        end else begin
            m_ready <= 1'b1;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    task automatic write_param(input logic [3:0] addr, input color_matrix_pkg::param_word_u word);
        int waited;
        param_addr <= addr;
        param_data <= word;
        param_req  <= 1'b1;
        waited = 0;
        @(posedge clk);
        while (param_ack !== 1'b1 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (param_ack !== 1'b1) begin
            $display("parameter write to address %0d was never acknowledged", addr);
            fail_count++;
        end
        param_req <= 1'b0;
        @(posedge clk);
        check_value("param_ack", param_ack, 1'b1);
        waited = 0;
        while (param_ack !== 1'b0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (param_ack !== 1'b0) begin
            $display("param_ack stayed high after the request was dropped");
            fail_count++;
        end
        if (addr < `CM_ADDR_CLIP0) begin
            sh_coef[addr] = word.coeff.value;
        end else if (addr < `CM_ADDR_CLIP0 + 3) begin
            sh_min[addr - `CM_ADDR_CLIP0] = word.clip.min;
            sh_max[addr - `CM_ADDR_CLIP0] = word.clip.max;
        end
    endtask

    task automatic load_set(input int coef [12], input int lo [3], input int hi [3]);
        color_matrix_pkg::param_word_u word;
        for (int i = 0; i < 12; i++) begin
            word = '0;
            word.coeff.value = 17'(coef[i]);
            write_param(4'(i), word);
        end
        for (int i = 0; i < 3; i++) begin
            word = '0;
            word.clip.min = 10'(lo[i]);
            word.clip.max = 10'(hi[i]);
            write_param(4'(`CM_ADDR_CLIP0 + i), word);
        end
    endtask

    task automatic send_rows(input int w, input int h, input int first, input int last,
                             input bit gaps);
        color_matrix_pkg::img_beat_t beat;
        int waited;
        for (int y = first; y <= last; y++) begin
            for (int x = 0; x < w; x++) begin
                if (gaps && ($random(seed) & 7) == 0) begin
                    s_valid <= 1'b0;
                    @(posedge clk);
                end
                beat.side.row_first = (y == 0);
                beat.side.row_last  = (y == h - 1);
                beat.side.col_first = (x == 0);
                beat.side.col_last  = (x == w - 1);
                beat.side.de        = 1'b1;
                for (int c = 0; c < 3; c++) begin
                    beat.color[c] = 10'($random(seed));
                end
                s_beat  <= beat;
                s_valid <= 1'b1;
                waited = 0;
                @(posedge clk);
                while (!s_ready && waited < TIMEOUT) begin
                    @(posedge clk);
                    waited++;
                end
                if (!s_ready) begin
                    $display("input beat at row %0d column %0d was never accepted", y, x);
                    fail_count++;
                end
            end
        end
        s_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || m_valid) && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("output stream stalled with %0d beats outstanding", exp_q.size());
            fail_count++;
        end
    endtask

    initial begin
        int set_a [12] = '{128, 128, 0, 0, 0, 0, 256, 16384, 256, 0, 0, 0};
        int lo_a [3]   = '{0, 0, 0};
        int hi_a [3]   = '{1023, 800, 1023};
        // negative gains and offset, overflow on row 1, min above max on channel 2
        int set_b [12] = '{-384, 512, 128, -25600, 768, 768, 768, 12800, -512, -64, 0, 0};
        int lo_b [3]   = '{64, 16, 600};
        int hi_b [3]   = '{940, 1000, 500};
        color_matrix_pkg::param_word_u junk;
        seed        = 32'h1f8c;
        clk         = 1'b0;
        reset       = 1'b1;
        s_beat      = '0;
        s_valid     = 1'b0;
        m_ready     = 1'b1;
        param_req   = 1'b0;
        param_addr  = '0;
        param_data  = '0;
        stall_en    = 1'b0;
        error_count = 0;
        fail_count  = 0;
        beat_count  = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("m_valid", m_valid, 1'b0);
        check_value("param_ack", param_ack, 1'b0);

        send_rows(8, 4, 0, 3, 1'b1);
        wait_drain();

        // new set written mid-frame, active from the next frame start
        send_rows(8, 4, 0, 1, 1'b0);
        load_set(set_a, lo_a, hi_a);
        send_rows(8, 4, 2, 3, 1'b0);
        send_rows(8, 4, 0, 3, 1'b1);
        wait_drain();

        load_set(set_b, lo_b, hi_b);
        send_rows(8, 4, 0, 3, 1'b1);
        wait_drain();

        stall_en <= 1'b1;
        send_rows(8, 4, 0, 3, 1'b1);
        send_rows(6, 3, 0, 2, 1'b1);

        junk = 20'($random(seed));
        write_param(4'd15, junk);
        send_rows(8, 4, 0, 3, 1'b1);
        stall_en <= 1'b0;
        wait_drain();

        $display("beats checked: %0d, value errors: %0d, other failures: %0d",
                 beat_count, error_count, fail_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: color_matrix_top.f
+incdir+common
common/color_matrix_pkg.sv
color_matrix/color_matrix_ctrl.sv
color_matrix/color_matrix_mac.sv
color_matrix/color_matrix_clip.sv
design/color_matrix_top.sv
verif/tb_color_matrix.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the color matrix testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f color_matrix_top.f \
    --top-module tb_color_matrix \
    -o sim_color_matrix

output=$(./obj_dir/sim_color_matrix)
echo "$output"

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
exit 1
